// File: rtl/backingMemory.sv
`timescale 1ns/10ps

module backingMemory (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               memRead,
  input  logic                               memWrite,
  input  logic [cachePkg::memAddrBits-1:0]   memAddr,
  input  logic [3:0]                         memByteEn,
  input  logic [7:0]                         storeData,
  output logic [31:0]                        memData,
  output logic                               memValid
);

  localparam int stageNum = cachePkg::memLatency - 1;  // last stage is memValid itself

  logic [31:0] memArray [2**cachePkg::memAddrBits];
  logic [stageNum-1:0] readValid;
  logic [cachePkg::memAddrBits-1:0] readAddr [stageNum];

  // byte-lane write-through
  always_ff @(posedge clk) begin
    if (memWrite) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (memByteEn[lane]) memArray[memAddr][lane*8 +: 8] <= storeData;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readValid <= '0;
      memValid <= 1'b0;
    end else begin
      readValid[0] <= memRead;
      for (int s = 1; s < stageNum; s++) begin
        readValid[s] <= readValid[s-1];
      end
      memValid <= readValid[stageNum-1];
    end
  end

  // address shift and read data, held until the next read
  always_ff @(posedge clk) begin
    readAddr[0] <= memAddr;
    for (int s = 1; s < stageNum; s++) begin
      readAddr[s] <= readAddr[s-1];
    end
    if (readValid[stageNum-1]) memData <= memArray[readAddr[stageNum-1]];
  end

endmodule

// File: rtl/cachePkg.sv
package cachePkg;

  // cache geometry, 8 sets x 2 ways, one word per line
  localparam int wayNum = 2;
  localparam int setNum = 8;
  localparam int setBits = 3;     // address bits 4:2
  localparam int offsetBits = 2;  // address bits 1:0
  localparam int tagBits = 27;    // address bits 31:5

  // backing memory, 256 words
  localparam int memAddrBits = 8;
  localparam int memLatency = 3;  // read strobe to memValid, in cycles

  // opcode held in the lookup stage
  typedef enum logic [1:0] {
    reqNone,
    reqLoad,
    reqStore
  } reqKindT;

  // load miss sequence
  typedef enum logic [1:0] {
    missIdle,  // lookup, read issued here on a miss
    missRead,  // waiting for memValid
    missFill   // line written, result returned
  } missStateT;

endpackage

// File: rtl/cacheRequest.sv
`timescale 1ns/10ps

module cacheRequest (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                loadReq,
  input  logic                                storeReq,
  input  logic [31:0]                         address,
  input  logic [7:0]                          storeData,
  input  logic                                hit,
  input  logic                                memValid,
  output logic [cachePkg::setBits-1:0]        lookupSet,
  output logic [cachePkg::tagBits-1:0]        lookupTag,
  output logic [cachePkg::offsetBits-1:0]     lookupOffset,
  output cachePkg::reqKindT                   lookupKind,
  output logic [7:0]                          lookupByte,
  output logic                                fillEn,
  output logic                                busy,
  output logic                                loadValid,
  output logic                                memRead,
  output logic                                memWrite,
  output logic [cachePkg::memAddrBits-1:0]    memAddr,
  output logic [3:0]                          memByteEn
);

  localparam int setLow = cachePkg::offsetBits;
  localparam int tagLow = cachePkg::offsetBits + cachePkg::setBits;

  cachePkg::missStateT missState;
  logic accept;
  logic loadMiss;

  // miss is only seen in the first lookup cycle of a load
  assign loadMiss = (missState == cachePkg::missIdle) && (lookupKind == cachePkg::reqLoad) && !hit;

  assign busy = loadMiss || (missState == cachePkg::missRead);
  assign accept = (loadReq || storeReq) && !busy;

  assign memRead = loadMiss;  // single pulse, state leaves missIdle next edge
  assign fillEn = (missState == cachePkg::missRead) && memValid;
  assign loadValid = ((missState == cachePkg::missIdle) && (lookupKind == cachePkg::reqLoad) && hit)
                     || (missState == cachePkg::missFill);

  // write-through, one byte lane per store
  assign memWrite = (lookupKind == cachePkg::reqStore);
  assign memByteEn = 4'b0001 << lookupOffset;
  assign memAddr = {lookupTag[cachePkg::memAddrBits-cachePkg::setBits-1:0], lookupSet};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lookupKind <= cachePkg::reqNone;
    end else if (!busy) begin
      if (accept) begin
        lookupKind <= storeReq ? cachePkg::reqStore : cachePkg::reqLoad;
      end else begin
        lookupKind <= cachePkg::reqNone;  // stage empties
      end
    end
  end

  // request payload, held while busy
  always_ff @(posedge clk) begin
    if (accept) begin
      lookupOffset <= address[cachePkg::offsetBits-1:0];
      lookupSet <= address[tagLow-1:setLow];
      lookupTag <= address[31:tagLow];
      lookupByte <= storeData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      missState <= cachePkg::missIdle;
    end else begin
      case (missState)
        cachePkg::missIdle: if (loadMiss) missState <= cachePkg::missRead;
        cachePkg::missRead: if (memValid) missState <= cachePkg::missFill;
        cachePkg::missFill: missState <= cachePkg::missIdle;  // loadValid cycle
        default: missState <= cachePkg::missIdle;
      endcase
    end
  end

endmodule

// File: rtl/cacheWay.sv
`timescale 1ns/10ps

module cacheWay (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic [cachePkg::setBits-1:0]       lookupSet,
  input  logic [cachePkg::tagBits-1:0]       lookupTag,
  input  logic [7:0]                         lookupByte,
  input  logic [cachePkg::offsetBits-1:0]    lookupOffset,
  input  logic [31:0]                        fillWord,
  input  logic                               fillEnable,
  input  logic                               storeEnable,
  output logic                               wayHit,
  output logic [31:0]                        wayWord
);

  logic [cachePkg::setNum-1:0] validBits;
  logic [cachePkg::tagBits-1:0] tagMem [cachePkg::setNum];
  logic [31:0] dataMem [cachePkg::setNum];

  // tag compare on the looked-up set
  assign wayHit = validBits[lookupSet] && (tagMem[lookupSet] == lookupTag);
  assign wayWord = dataMem[lookupSet];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validBits <= '0;
    end else if (fillEnable) begin
      validBits[lookupSet] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEnable) begin
      tagMem[lookupSet] <= lookupTag;
      dataMem[lookupSet] <= fillWord;  // whole line
    end else if (storeEnable) begin
      // store hit, one lane only
      dataMem[lookupSet][{lookupOffset, 3'b000} +: 8] <= lookupByte;
    end
  end

endmodule

// File: rtl/dataCacheTop.sv
`timescale 1ns/10ps

module dataCacheTop (
  input  logic          clk,
  input  logic          rstN,
  input  logic          loadReq,
  input  logic          storeReq,
  input  logic [31:0]   address,
  input  logic [7:0]    storeData,
  output logic [31:0]   loadData,
  output logic          loadValid,
  output logic          hit,
  output logic          busy
);

  logic [cachePkg::setBits-1:0] lookupSet;
  logic [cachePkg::tagBits-1:0] lookupTag;
  logic [cachePkg::offsetBits-1:0] lookupOffset;
  cachePkg::reqKindT lookupKind;
  logic [7:0] lookupByte;
  logic fillEn;

  logic [cachePkg::wayNum-1:0] wayHit;
  logic [cachePkg::wayNum-1:0][31:0] wayWord;
  logic [cachePkg::wayNum-1:0] fillWay;
  logic [cachePkg::wayNum-1:0] storeWay;

  logic memRead;
  logic memWrite;
  logic [cachePkg::memAddrBits-1:0] memAddr;
  logic [3:0] memByteEn;
  logic [31:0] memData;
  logic memValid;

  cacheRequest requestCtrl (
    .clk(clk), .rstN(rstN), .loadReq(loadReq), .storeReq(storeReq),
    .address(address), .storeData(storeData), .hit(hit), .memValid(memValid),
    .lookupSet(lookupSet), .lookupTag(lookupTag), .lookupOffset(lookupOffset),
    .lookupKind(lookupKind), .lookupByte(lookupByte), .fillEn(fillEn),
    .busy(busy), .loadValid(loadValid), .memRead(memRead), .memWrite(memWrite),
    .memAddr(memAddr), .memByteEn(memByteEn)
  );

  for (genvar w = 0; w < cachePkg::wayNum; w++) begin : genWay
    cacheWay way (
      .clk(clk), .rstN(rstN), .lookupSet(lookupSet), .lookupTag(lookupTag),
      .lookupByte(lookupByte), .lookupOffset(lookupOffset),
      .fillWord(memData),  // fills come straight from memory
      .fillEnable(fillWay[w]), .storeEnable(storeWay[w]),
      .wayHit(wayHit[w]), .wayWord(wayWord[w])
    );
  end

  wayResolve resolver (
    .clk(clk), .rstN(rstN), .wayHit(wayHit), .wayWord(wayWord), .memData(memData),
    .lookupSet(lookupSet), .lookupOffset(lookupOffset), .lookupKind(lookupKind),
    .fillEn(fillEn), .hit(hit), .loadData(loadData), .fillWay(fillWay),
    .storeWay(storeWay)
  );

  // store byte from the lookup stage, same as the ways
  backingMemory memory (
    .clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
    .memAddr(memAddr), .memByteEn(memByteEn), .storeData(lookupByte),
    .memData(memData), .memValid(memValid)
  );

endmodule

// File: rtl/wayResolve.sv
`timescale 1ns/10ps

module wayResolve (
  input  logic                                  clk,
  input  logic                                  rstN,
  input  logic [cachePkg::wayNum-1:0]           wayHit,
  input  logic [cachePkg::wayNum-1:0][31:0]     wayWord,
  input  logic [31:0]                           memData,
  input  logic [cachePkg::setBits-1:0]          lookupSet,
  input  logic [cachePkg::offsetBits-1:0]       lookupOffset,
  input  cachePkg::reqKindT                     lookupKind,
  input  logic                                  fillEn,
  output logic                                  hit,
  output logic [31:0]                           loadData,
  output logic [cachePkg::wayNum-1:0]           fillWay,
  output logic [cachePkg::wayNum-1:0]           storeWay
);

  logic [cachePkg::setNum-1:0] lru;  // names the way to fill next
  logic fillDone;
  logic hitIdx;
  logic [31:0] hitWord;
  logic [31:0] selWord;

  always_comb begin
    hitWord = '0;
    hitIdx = 1'b0;
    for (int w = 0; w < cachePkg::wayNum; w++) begin
      if (wayHit[w]) begin
        hitWord |= wayWord[w];
        hitIdx = 1'(w);
      end
    end
  end

  // line was just filled, so the result still counts as a miss
  assign hit = (|wayHit) && !fillDone && (lookupKind != cachePkg::reqNone);

  assign selWord = hit ? hitWord : memData;
  assign loadData = {24'b0, selWord[{lookupOffset, 3'b000} +: 8]};

  always_comb begin
    for (int w = 0; w < cachePkg::wayNum; w++) begin
      fillWay[w] = fillEn && (lru[lookupSet] == 1'(w));
    end
  end

  assign storeWay = wayHit & {cachePkg::wayNum{lookupKind == cachePkg::reqStore}};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lru <= '0;
      fillDone <= 1'b0;
    end else begin
      fillDone <= fillEn;
      if (fillEn) begin
        lru[lookupSet] <= ~lru[lookupSet];  // filled way becomes most recent
      end else if (hit) begin
        lru[lookupSet] <= ~hitIdx;  // load or store hit
      end
    end
  end

endmodule

// File: tb.f
rtl/cachePkg.sv
rtl/cacheRequest.sv
rtl/cacheWay.sv
rtl/wayResolve.sv
rtl/backingMemory.sv
rtl/dataCacheTop.sv
testbench/tbClock.sv
testbench/cacheTb.sv

// File: testbench/cacheTb.sv
`timescale 1ns/10ps

module cacheTb;

  localparam int resetCycles = 16;
  localparam int directedRequests = 33;
  localparam int randomRequests = 200;
  localparam int cycleLimit = 2 * (6 * (directedRequests + randomRequests) + resetCycles);
  localparam int loadWaitLimit = 20;

  logic clk;
  logic rstN;
  logic loadReq;
  logic storeReq;
  logic [31:0] address;
  logic [7:0] storeData;
  logic [31:0] loadData;
  logic loadValid;
  logic hit;
  logic busy;

  logic [7:0] shadow [1024];  // byte image of the backing memory
  bit written [1024];
  bit modelValid [cachePkg::setNum][cachePkg::wayNum];
  int modelTag [cachePkg::setNum][cachePkg::wayNum];
  bit modelLru [cachePkg::setNum];  // way to fill next
  int cycleCount = 0;
  int validCount = 0;
  int loadsIssued = 0;
  logic [31:0] rngState = 32'd69270;

  tbClock clockGen (.clk(clk));

  dataCacheTop UUT (
    .clk(clk), .rstN(rstN), .loadReq(loadReq), .storeReq(storeReq), .address(address),
    .storeData(storeData), .loadData(loadData), .loadValid(loadValid), .hit(hit), .busy(busy)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // returns the predicted hit and moves the model on by one access
  function automatic bit updateModel(input bit isStore, input logic [31:0] addr);
    int setIdx;
    int tag;
    int way;
    setIdx = addr[4:2];
    tag = addr[31:5];
    way = -1;
    for (int w = 0; w < cachePkg::wayNum; w++) begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) way = w;
    end
    if (way >= 0) begin
      modelLru[setIdx] = (way == 0) ? 1'b1 : 1'b0;  // other way is now the older one
      return 1'b1;
    end
    if (!isStore) begin  // stores never allocate
      modelValid[setIdx][modelLru[setIdx]] = 1'b1;
      modelTag[setIdx][modelLru[setIdx]] = tag;
      modelLru[setIdx] = !modelLru[setIdx];
    end
    return 1'b0;
  endfunction

  // holds the strobe until an edge with busy low takes it
  task automatic sendRequest(input bit isStore, input logic [31:0] addr, input logic [7:0] data);
    @(posedge clk);
    loadReq <= !isStore;
    storeReq <= isStore;
    address <= addr;
    storeData <= data;
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);  // accepted here
    loadReq <= 1'b0;
    storeReq <= 1'b0;
  endtask

  task automatic waitLoadValid(output int cycles);
    cycles = 1;
    @(negedge clk);
    while (!loadValid) begin
      if (cycles >= loadWaitLimit) abortRun("loadValid never arrived for an accepted load");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic checkLoad(input logic [31:0] expData, input bit expHit);
    assert (loadData === expData) else
      abortRun($sformatf("Error: loadData expected 0x%08h, got 0x%08h", expData, loadData));
    assert (hit === expHit) else
      abortRun($sformatf("Error: hit expected 0x%0h, got 0x%0h", expHit, hit));
  endtask

  task automatic doStore(input logic [31:0] addr, input logic [7:0] data);
    void'(updateModel(1'b1, addr));
    shadow[addr[9:0]] = data;
    written[addr[9:0]] = 1'b1;
    sendRequest(1'b1, addr, data);
  endtask

  task automatic doLoad(input logic [31:0] addr);
    bit expHit;
    int latency;
    int expLatency;
    assert (written[addr[9:0]]) else abortRun("a load was issued to a byte never stored");
    expHit = updateModel(1'b0, addr);
    expLatency = expHit ? 1 : 2 + cachePkg::memLatency;
    sendRequest(1'b0, addr, 8'h00);
    loadsIssued++;
    waitLoadValid(latency);
    checkLoad({24'b0, shadow[addr[9:0]]}, expHit);
    assert (latency == expLatency) else
      abortRun($sformatf("Error: loadValid latency expected 0x%0h, got 0x%0h",
                         expLatency, latency));
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) abortRun("run stopped by the cycle limit, the DUT stalled");
  end

  always @(negedge clk) begin
    if (rstN) begin
      assert (!(loadValid && busy)) else abortRun("busy was still high in a loadValid cycle");
      if (loadValid) validCount <= validCount + 1;
    end
  end

  initial begin
    bit expHit;
    bit isStore;
    int latency;
    logic [31:0] randAddr;
    rstN = 1'b0;
    loadReq = 1'b0;
    storeReq = 1'b0;
    address = '0;
    storeData = '0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;

    @(negedge clk);
    assert (!loadValid) else
      abortRun($sformatf("Error: loadValid expected 0x0 after reset, got 0x%0h", loadValid));
    assert (!busy) else
      abortRun($sformatf("Error: busy expected 0x0 after reset, got 0x%0h", busy));
    doStore(32'h040, 8'h3c);
    doLoad(32'h040);  // cold miss at full latency

    // byte lanes of one word
    for (int b = 0; b < 4; b++) doStore(32'h104 + b, 8'ha1 + 8'h33 * b);
    for (int b = 0; b < 4; b++) doLoad(32'h104 + b);
    for (int b = 3; b >= 0; b--) doLoad(32'h104 + b);

    // A, B, C, D share set 3
    doStore(32'h00d, 8'h11);
    doStore(32'h02d, 8'h22);
    doStore(32'h04d, 8'h33);
    doLoad(32'h00d);
    doLoad(32'h02d);
    doLoad(32'h00d);
    doLoad(32'h04d);  // evicts B
    doLoad(32'h00d);
    doLoad(32'h02d);

    doStore(32'h00d, 8'h9a);  // store hit
    doLoad(32'h00d);
    doStore(32'h04d, 8'h7e);  // C no longer cached
    doLoad(32'h04d);

    // strobes thrown at a load miss
    doStore(32'h06d, 8'h5d);
    expHit = updateModel(1'b0, 32'h06d);
    sendRequest(1'b0, 32'h06d, 8'h00);
    loadsIssued++;
    storeReq <= 1'b1;
    address <= 32'h00d;
    storeData <= 8'hee;
    @(negedge clk);
    assert (busy) else abortRun("busy was low in the lookup cycle of a load miss");
    @(posedge clk);
    storeReq <= 1'b0;
    loadReq <= 1'b1;
    address <= 32'h04d;
    @(negedge clk);
    assert (busy) else abortRun("busy dropped while a load miss waited for memory");
    @(posedge clk);
    loadReq <= 1'b0;
    waitLoadValid(latency);
    // two miss cycles went by while the strobes were dropped
    assert (latency + 2 == 2 + cachePkg::memLatency) else
      abortRun($sformatf("Error: loadValid latency expected 0x%0h, got 0x%0h",
                         2 + cachePkg::memLatency, latency + 2));
    checkLoad({24'b0, shadow[10'h06d]}, expHit);
    repeat (8) @(posedge clk);
    assert (validCount == loadsIssued) else
      abortRun($sformatf("Error: loadValid count expected 0x%0h, got 0x%0h",
                         loadsIssued, validCount));
    doLoad(32'h00d);  // dropped store left it alone

    // 64 bytes over four tags and all eight sets
    for (int i = 0; i < randomRequests; i++) begin
      rngState = xorshift32(rngState);
      randAddr = 32'h200 + {25'b0, rngState[4:3], rngState[2:0], rngState[5], 1'b1};
      isStore = rngState[8] || !written[randAddr[9:0]];
      if (isStore) doStore(randAddr, rngState[23:16]);
      else doLoad(randAddr);
    end

    repeat (4) @(posedge clk);
    assert (validCount == loadsIssued) else
      abortRun($sformatf("Error: loadValid count expected 0x%0h, got 0x%0h",
                         loadsIssued, validCount));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/10ps

module tbClock (
  output logic clk
);

  localparam int halfPeriod = 10;  // 20 ns period

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

endmodule
